// File: sources.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/pmp_pkg.sv
verilog/pmp_csr_bank.sv
verilog/stack_bound_tracker.sv
verilog/region_checker.sv
verilog/pmp.sv
bench/pmp_sva.sv
bench/pmp_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PMP testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module pmp_tb \
    --Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vpmp_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    echo "FAIL"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1

// File: bench/pmp_tb.sv
`timescale 1ns/1ps
`include "pmp_config.svh"

module pmp_tb;

    localparam int CLK_PERIOD = 100;
    localparam int ADDR_CSRS  = `PMP_TASKS * `PMP_ROWS;

    logic                          clk;
    logic                          reset;
    csr_pkg::csr_req_t             csr_req;
    logic [`PMP_XLEN-1:0]          csr_rdata;
    pmp_pkg::mem_access_t          access;
    logic                          task_entry;
    logic [pmp_pkg::TASK_ID_W-1:0] entry_id;
    logic [`PMP_AW-1:0]            sp;
    logic                          enable;
    logic                          mem_fault;

    // Reference copies of the CSR words and boundaries
    logic [`PMP_XLEN-1:0] addr_words [ADDR_CSRS];
    logic [`PMP_XLEN-1:0] cfg_words [`PMP_TASKS];
    logic [`PMP_AW-1:0]   bound_model [`PMP_TASKS];
    logic                 exp_fault; // Due one cycle after its access
    bit                   fell;

    pmp dut (
        .clk        (clk),
        .reset      (reset),
        .csr_req    (csr_req),
        .csr_rdata  (csr_rdata),
        .access     (access),
        .task_entry (task_entry),
        .entry_id   (entry_id),
        .sp         (sp),
        .enable     (enable),
        .mem_fault  (mem_fault)
    );

    bind pmp pmp_sva u_sva (
        .clk       (clk),
        .reset     (reset),
        .csr_req   (csr_req),
        .access    (access),
        .enable    (enable),
        .mem_fault (mem_fault),
        .rows_cfg  (rows_cfg)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("ERROR t=%0t %s got %h expected %h",
                               $time, name, got, expected));
        end
    endtask

    // Each falling edge has two clock periods to show up
    task wait_falls(input int n);
        for (int i = 0; i < n; i++) begin
            fell = 1'b0;
            fork
                begin
                    @(negedge clk);
                    fell = 1'b1;
                end
                begin
                    #(2 * CLK_PERIOD);
                end
            join_any
            disable fork;
            if (!fell) begin
                fail_run("the clock stopped, no falling edge within two periods");
            end
        end
    endtask

    task automatic clear_reference();
        for (int i = 0; i < ADDR_CSRS; i++) begin
            addr_words[i] = '0;
        end
        for (int t = 0; t < `PMP_TASKS; t++) begin
            cfg_words[t]   = '0;
            bound_model[t] = '0;
        end
        exp_fault = 1'b0;
    endtask

    function automatic logic [31:0] read_expected(input logic [11:0] addr);
        int idx;
        read_expected = '0;
        idx = int'(addr) - int'(`PMP_ADDR_CSR_BASE);
        if (idx >= 0 && idx < ADDR_CSRS) begin
            read_expected = addr_words[idx];
        end
        idx = int'(addr) - int'(`PMP_CFG_CSR_BASE);
        if (idx >= 0 && idx < `PMP_TASKS) begin
            read_expected = cfg_words[idx];
        end
    endfunction

    task automatic update_reference(input csr_pkg::csr_req_t req);
        logic [31:0] operand;
        logic [31:0] new_word;
        int          idx;
        if (!req.enable || req.op == csr_pkg::CSR_NONE) begin
            return;
        end
        operand = req.use_imm ? {27'b0, req.zimm} : req.rs1_data;
        case (req.op)
            csr_pkg::CSR_WRITE: new_word = operand;
            csr_pkg::CSR_SET:   new_word = read_expected(req.addr) | operand;
            default:            new_word = read_expected(req.addr) & ~operand;
        endcase
        idx = int'(req.addr) - int'(`PMP_ADDR_CSR_BASE);
        // Lock bit of the row is bit 7 of its byte in the task word
        if (idx >= 0 && idx < ADDR_CSRS) begin
            if (!cfg_words[idx / `PMP_ROWS][8 * (idx % `PMP_ROWS) + 7]) begin
                addr_words[idx] = new_word;
            end
        end
        idx = int'(req.addr) - int'(`PMP_CFG_CSR_BASE);
        if (idx >= 0 && idx < `PMP_TASKS) begin
            for (int b = 0; b < `PMP_ROWS; b++) begin
                if (!cfg_words[idx][8 * b + 7]) begin
                    cfg_words[idx][8 * b +: 8] = new_word[8 * b +: 8];
                end
            end
        end
    endtask

    function automatic logic predict_fault(input pmp_pkg::mem_access_t acc, input logic en);
        logic        is_load;
        logic        is_store;
        logic        granted;
        logic [7:0]  cfg_byte;
        logic [31:0] window;
        is_load  = acc.opcode == pmp_pkg::OP_LOAD;
        is_store = acc.opcode == pmp_pkg::OP_STORE;
        granted  = 1'b0;
        for (int r = 0; r < `PMP_ROWS; r++) begin
            cfg_byte = cfg_words[acc.id][8 * r +: 8];
            window   = addr_words[int'(acc.id) * `PMP_ROWS + r];
            if (cfg_byte[5:3] != 3'd0 && window[15:0] <= acc.addr && acc.addr <= window[31:16]
                && ((is_load && cfg_byte[0]) || (is_store && cfg_byte[1]))) begin
                granted = 1'b1;
            end
        end
        return en && (is_load || is_store) && (acc.addr < bound_model[acc.id]) && !granted;
    endfunction

    function automatic csr_pkg::csr_req_t make_csr_req(input int lock_pct);
        csr_pkg::csr_req_t req;
        logic [15:0]       lower;
        logic [31:0]       lock_mask;
        int                pick;
        req.enable  = $urandom_range(3) != 0;
        req.op      = csr_pkg::csr_op_t'(2'($urandom_range(3)));
        req.use_imm = 1'($urandom_range(1));
        req.zimm    = 5'($urandom);
        pick        = $urandom_range(9);
        if (pick < 5) begin
            req.addr     = `PMP_ADDR_CSR_BASE + 12'($urandom_range(ADDR_CSRS - 1));
            lower        = 16'($urandom);
            req.rs1_data = {lower + 16'($urandom_range(4095)), lower}; // Mostly sane windows
        end else if (pick < 8) begin
            req.addr  = `PMP_CFG_CSR_BASE + 12'($urandom_range(`PMP_TASKS - 1));
            lock_mask = '0;
            for (int b = 0; b < `PMP_ROWS; b++) begin
                if ($urandom_range(99) < lock_pct) begin
                    lock_mask[8 * b + 7] = 1'b1;
                end
            end
            req.rs1_data = ($urandom & 32'h7f7f_7f7f) | lock_mask;
        end else begin
            req.addr     = 12'($urandom); // Nearly always unmapped
            req.rs1_data = $urandom;
        end
        return req;
    endfunction

    function automatic pmp_pkg::mem_access_t make_access();
        pmp_pkg::mem_access_t acc;
        logic [31:0]          window;
        int                   pick;
        acc.id = 3'($urandom_range(`PMP_TASKS - 1));
        pick   = $urandom_range(9);
        if (pick < 4) begin
            acc.opcode = pmp_pkg::OP_LOAD;
        end else if (pick < 8) begin
            acc.opcode = pmp_pkg::OP_STORE;
        end else begin
            acc.opcode = 7'($urandom);
        end
        window = addr_words[int'(acc.id) * `PMP_ROWS + $urandom_range(`PMP_ROWS - 1)];
        if ($urandom_range(1) == 1) begin
            acc.addr = window[15:0] + 16'($urandom_range(15)); // Near a row window
        end else begin
            acc.addr = 16'($urandom);
        end
        return acc;
    endfunction

    // One access and one CSR request per cycle, driven at the falling edge
    task automatic run_phase(input int cycles, input int lock_pct);
        csr_pkg::csr_req_t    req;
        pmp_pkg::mem_access_t acc;
        for (int c = 0; c < cycles; c++) begin
            check_value("mem_fault", 32'(mem_fault), 32'(exp_fault));
            req        = make_csr_req(lock_pct);
            acc        = make_access();
            csr_req    = req;
            access     = acc;
            enable     = $urandom_range(9) != 0;
            task_entry = $urandom_range(3) == 0;
            entry_id   = 3'($urandom_range(`PMP_TASKS - 1));
            sp         = 16'($urandom);
            #1;
            check_value("csr_rdata", csr_rdata, read_expected(req.addr));
            exp_fault = predict_fault(acc, enable);
            update_reference(req);
            if (task_entry) begin
                bound_model[entry_id] = sp; // Seen by accesses from the next cycle
            end
            wait_falls(1);
        end
        check_value("mem_fault", 32'(mem_fault), 32'(exp_fault));
    endtask

    initial begin
        void'($urandom(32'h7dde_e2c2));
        reset       = 1'b1;
        csr_req     = '0;
        access      = '0;
        task_entry  = 1'b0;
        entry_id    = '0;
        sp          = '0;
        enable      = 1'b0;
        clear_reference();
        wait_falls(2);
        reset = 1'b0;
        run_phase(3000, 2);
        // Second reset must free every lock; then lock far more often
        reset = 1'b1;
        wait_falls(2);
        reset = 1'b0;
        clear_reference();
        run_phase(3000, 30);
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: bench/pmp_sva.sv
`timescale 1ns/1ps
`include "pmp_config.svh"

// Protocol properties of the PMP top level
module pmp_sva (
    input logic                                              clk,
    input logic                                              reset,
    input csr_pkg::csr_req_t                                 csr_req,
    input pmp_pkg::mem_access_t                              access,
    input logic                                              enable,
    input logic                                              mem_fault,
    input pmp_pkg::pmp_cfg_t [`PMP_TASKS-1:0][`PMP_ROWS-1:0] rows_cfg
);

    logic mem_op;
    logic csr_write;

    assign mem_op    = (access.opcode == pmp_pkg::OP_LOAD) ||
                       (access.opcode == pmp_pkg::OP_STORE);
    assign csr_write = csr_req.enable && (csr_req.op != csr_pkg::CSR_NONE);

    reset_clears_fault: assert property (@(posedge clk) reset |=> !mem_fault)
        else $error("mem_fault high in the cycle after reset");

    // A fault needs an enabled load or store one cycle earlier
    fault_has_cause: assert property (@(posedge clk) disable iff (reset)
        mem_fault |-> $past(enable) && $past(mem_op))
        else $error("mem_fault without an enabled load or store before it");

    for (genvar t = 0; t < `PMP_TASKS; t++) begin : g_task
        for (genvar r = 0; r < `PMP_ROWS; r++) begin : g_row
            locked_byte_holds: assert property (@(posedge clk) disable iff (reset)
                csr_write && rows_cfg[t][r].locked |=> $stable(rows_cfg[t][r]))
                else $error("locked configuration byte changed, task %0d row %0d", t, r);
        end
    end

endmodule

// File: verilog/pmp.sv
`timescale 1ns/1ps
`include "pmp_config.svh"

// Physical memory protection for data accesses of the hardware tasks
module pmp (
    input  logic                          clk,
    input  logic                          reset,
    input  csr_pkg::csr_req_t             csr_req,
    output logic [`PMP_XLEN-1:0]          csr_rdata,
    input  pmp_pkg::mem_access_t          access,
    input  logic                          task_entry,
    input  logic [pmp_pkg::TASK_ID_W-1:0] entry_id,
    input  logic [`PMP_AW-1:0]            sp,
    input  logic                          enable,
    output logic                          mem_fault
);

    pmp_pkg::pmp_addr_t [`PMP_TASKS-1:0][`PMP_ROWS-1:0] rows_addr;
    pmp_pkg::pmp_cfg_t  [`PMP_TASKS-1:0][`PMP_ROWS-1:0] rows_cfg;
    logic [`PMP_TASKS-1:0][`PMP_AW-1:0]                 bounds;

    pmp_csr_bank u_csr_bank (
        .clk       (clk),
        .reset     (reset),
        .csr_req   (csr_req),
        .csr_rdata (csr_rdata),
        .rows_addr (rows_addr),
        .rows_cfg  (rows_cfg)
    );

    stack_bound_tracker u_bound_tracker (
        .clk        (clk),
        .reset      (reset),
        .task_entry (task_entry),
        .entry_id   (entry_id),
        .sp         (sp),
        .bounds     (bounds)
    );

    region_checker u_region_checker (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .access    (access),
        .bounds    (bounds),
        .rows_addr (rows_addr),
        .rows_cfg  (rows_cfg),
        .mem_fault (mem_fault)
    );

endmodule

// File: verilog/region_checker.sv
`timescale 1ns/1ps
`include "pmp_config.svh"

// Fault decision for one data access, registered
module region_checker (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              enable,
    input  pmp_pkg::mem_access_t                              access,
    input  logic [`PMP_TASKS-1:0][`PMP_AW-1:0]                bounds,
    input  pmp_pkg::pmp_addr_t [`PMP_TASKS-1:0][`PMP_ROWS-1:0] rows_addr,
    input  pmp_pkg::pmp_cfg_t  [`PMP_TASKS-1:0][`PMP_ROWS-1:0] rows_cfg,
    output logic                                              mem_fault
);

    pmp_pkg::pmp_addr_t [`PMP_ROWS-1:0] task_addr;
    pmp_pkg::pmp_cfg_t  [`PMP_ROWS-1:0] task_cfg;
    logic [`PMP_AW-1:0]                 task_bound;
    logic [`PMP_ROWS-1:0]               row_grant;
    logic                               is_load;
    logic                               is_store;
    logic                               below_bound;
    logic                               fault_next;

    // Only the rows of the accessing task take part
    assign task_addr  = rows_addr[access.id];
    assign task_cfg   = rows_cfg[access.id];
    assign task_bound = bounds[access.id];

    assign is_load     = access.opcode == pmp_pkg::OP_LOAD;
    assign is_store    = access.opcode == pmp_pkg::OP_STORE;
    assign below_bound = access.addr < task_bound;

    for (genvar r = 0; r < `PMP_ROWS; r++) begin : g_row
        logic in_window;
        logic kind_ok;

        assign in_window = (task_addr[r].lower_bound <= access.addr) &&
                           (access.addr <= task_addr[r].upper_bound);
        // exec_en plays no part on the data side
        assign kind_ok   = (is_load && task_cfg[r].read_en) ||
                           (is_store && task_cfg[r].write_en);
        assign row_grant[r] = (task_cfg[r].mode != 3'd0) && in_window && kind_ok;
    end

    // Any single granting row clears the fault
    assign fault_next = enable && (is_load || is_store) && below_bound && !(|row_grant);

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_fault <= 1'b0;
        end else begin
            mem_fault <= fault_next;
        end
    end

endmodule

// File: verilog/stack_bound_tracker.sv
`timescale 1ns/1ps
`include "pmp_config.svh"

// Captures the stack pointer of each task as it is entered
module stack_bound_tracker (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  task_entry,
    input  logic [pmp_pkg::TASK_ID_W-1:0]         entry_id,
    input  logic [`PMP_AW-1:0]                    sp,
    output logic [`PMP_TASKS-1:0][`PMP_AW-1:0]    bounds
);

    logic [`PMP_TASKS-1:0] load_en;

    // One-hot load strobe from the entering task
    always_comb begin
        load_en = '0;
        if (task_entry) begin
            load_en[entry_id] = 1'b1;
        end
    end

    for (genvar t = 0; t < `PMP_TASKS; t++) begin : g_bound
        always_ff @(posedge clk) begin
            if (reset) begin
                bounds[t] <= '0; // Nothing lies below zero, so no fault
            end else if (load_en[t]) begin
                bounds[t] <= sp;
            end
        end
    end

endmodule

// File: verilog/pmp_csr_bank.sv
`timescale 1ns/1ps
`include "pmp_config.svh"

// Row address and configuration registers of every task behind the CSR port
module pmp_csr_bank (
    input  logic                                              clk,
    input  logic                                              reset,
    input  csr_pkg::csr_req_t                                 csr_req,
    output logic [`PMP_XLEN-1:0]                              csr_rdata,
    output pmp_pkg::pmp_addr_t [`PMP_TASKS-1:0][`PMP_ROWS-1:0] rows_addr,
    output pmp_pkg::pmp_cfg_t  [`PMP_TASKS-1:0][`PMP_ROWS-1:0] rows_cfg
);

    localparam int ADDR_CSRS = `PMP_TASKS * `PMP_ROWS;
    localparam int ROW_W     = $clog2(`PMP_ROWS);
    localparam int TASK_W    = pmp_pkg::TASK_ID_W;

    logic [csr_pkg::CSR_ADDR_W-1:0] addr_off;
    logic [csr_pkg::CSR_ADDR_W-1:0] cfg_off;
    logic                           addr_hit;
    logic                           cfg_hit;
    logic [TASK_W-1:0]              addr_task;
    logic [ROW_W-1:0]               addr_row;
    logic [TASK_W-1:0]              cfg_task;
    logic                           do_write;
    logic [`PMP_XLEN-1:0]           operand;
    pmp_pkg::pmp_csr_word_u         old_word;
    pmp_pkg::pmp_csr_word_u         new_word;

    // Below the base the offset wraps high and misses the range check
    assign addr_off = csr_req.addr - `PMP_ADDR_CSR_BASE;
    assign cfg_off  = csr_req.addr - `PMP_CFG_CSR_BASE;
    assign addr_hit = addr_off < ADDR_CSRS;
    assign cfg_hit  = cfg_off < `PMP_TASKS;

    assign addr_task = addr_off[ROW_W +: TASK_W]; // Task major layout
    assign addr_row  = addr_off[ROW_W-1:0];
    assign cfg_task  = cfg_off[TASK_W-1:0];

    // Current contents of the addressed CSR, zero when unmapped
    always_comb begin
        old_word = '0;
        if (addr_hit) begin
            old_word.addr = rows_addr[addr_task][addr_row];
        end else if (cfg_hit) begin
            old_word.cfg = rows_cfg[cfg_task];
        end
    end

    assign csr_rdata = old_word;

    assign operand = csr_req.use_imm ? `PMP_XLEN'(csr_req.zimm) : csr_req.rs1_data;

    always_comb begin
        unique case (csr_req.op)
            csr_pkg::CSR_WRITE: new_word = pmp_pkg::pmp_csr_word_u'(operand);
            csr_pkg::CSR_SET:   new_word = pmp_pkg::pmp_csr_word_u'(old_word | operand);
            csr_pkg::CSR_CLEAR: new_word = pmp_pkg::pmp_csr_word_u'(old_word & ~operand);
            default:            new_word = old_word;
        endcase
    end

    assign do_write = csr_req.enable && (csr_req.op != csr_pkg::CSR_NONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            rows_addr <= '0;
            rows_cfg  <= '0;
        end else if (do_write) begin
            // A locked row also freezes its address window
            if (addr_hit && !rows_cfg[addr_task][addr_row].locked) begin
                rows_addr[addr_task][addr_row] <= new_word.addr;
            end
            if (cfg_hit) begin
                for (int i = 0; i < `PMP_ROWS; i++) begin
                    if (!rows_cfg[cfg_task][i].locked) begin
                        rows_cfg[cfg_task][i] <= new_word.cfg[i];
                    end
                end
            end
        end
    end

endmodule

// File: verilog/pmp_pkg.sv
`include "pmp_config.svh"

package pmp_pkg;

    localparam int TASK_ID_W = $clog2(`PMP_TASKS);
    localparam int OPCODE_W  = 7;

    // Major opcodes of the RV32 load and store groups
    localparam logic [OPCODE_W-1:0] OP_LOAD  = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OP_STORE = 7'b0100011;

    // One configuration byte per protection row
    typedef struct packed {
        logic       locked;   // Frees only on reset
        logic       reserved;
        logic [2:0] mode;     // Nonzero makes the row active
        logic       exec_en;  // Stored, not enforced
        logic       write_en;
        logic       read_en;
    } pmp_cfg_t;

    // Inclusive address window of a row
    typedef struct packed {
        logic [`PMP_AW-1:0] upper_bound;
        logic [`PMP_AW-1:0] lower_bound;
    } pmp_addr_t;

    // A CSR word seen as a row address or as the row bytes of one task
    typedef union packed {
        pmp_addr_t                  addr;
        pmp_cfg_t [`PMP_ROWS-1:0]   cfg;  // Byte i belongs to row i
    } pmp_csr_word_u;

    // Data memory access leaving the execute stage
    typedef struct packed {
        logic [`PMP_AW-1:0]   addr;
        logic [OPCODE_W-1:0]  opcode;
        logic [TASK_ID_W-1:0] id;
    } mem_access_t;

endpackage

// File: verilog/csr_pkg.sv
`include "pmp_config.svh"

package csr_pkg;

    localparam int CSR_ADDR_W = 12; // Standard RISC-V CSR address space
    localparam int ZIMM_W     = 5;

    // Read-modify-write kind of a CSR instruction
    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1, // csrrw / csrrwi
        CSR_SET   = 2'd2, // csrrs / csrrsi
        CSR_CLEAR = 2'd3  // csrrc / csrrci
    } csr_op_t;

    // One CSR access as issued by the decode stage
    typedef struct packed {
        logic                  enable;
        logic [CSR_ADDR_W-1:0] addr;
        csr_op_t               op;
        logic                  use_imm;  // Take zimm instead of rs1
        logic [ZIMM_W-1:0]     zimm;
        logic [`PMP_XLEN-1:0]  rs1_data;
    } csr_req_t;

endpackage

// File: verilog/pmp_config.svh
`ifndef PMP_CONFIG_SVH
`define PMP_CONFIG_SVH

// Hardware task count, one stack boundary each
`define PMP_TASKS 8

// Protection rows per task
// Kept at 4 so a single configuration word covers one task
`define PMP_ROWS 4

// Data address width of the core
`define PMP_AW 16

// CSR word width
`define PMP_XLEN 32

// Address CSRs, one per row, task major
`define PMP_ADDR_CSR_BASE 12'h400

// Configuration CSRs, one word per task
`define PMP_CFG_CSR_BASE 12'h480

`endif
